//--- tb.f
hw/priv_pkg.sv
hw/priv_csr.sv
hw/priv_pma_regs.sv
hw/priv_ctrl.sv
hw/priv_top.sv
sim/tb_clk.sv
sim/priv_chk.sv
sim/priv_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = priv_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/priv_tb.sv
/* Table-driven testbench for priv_top. Expected values come from a small
   model of the CSR, trap and MRET rules, built before the run.
   Only the CSRs that the table touches are modelled. The first mismatch
   or a timeout ends the run. */
`timescale 1ns/1ns

module priv_tb;
  import priv_pkg::*;

  localparam int HARTID      = 3;
  localparam int PMA_REGIONS = 4;
  localparam int RST_CYCLES  = 8;
  localparam int DRIVE_DLY   = 2;
  localparam int EXTRA_REQS  = 10;  // Counter and interrupt requests
  localparam int MARGIN      = 40;

  typedef struct packed {
    csr_op_t     op;
    csr_addr_t   addr;
    csr_reg_t    wdata;
    csr_reg_t    epc;
    csr_reg_t    cause;
    csr_reg_t    tval;
    csr_reg_t    exp_rdata;
    logic        exp_invalid;
    priv_level_t exp_priv;
  } row_t;

  logic        CLK, nRST;
  logic        req, inst_ret, irq_timer, irq_ext;
  csr_op_t     op;
  csr_addr_t   addr;
  csr_reg_t    wdata, epc, cause, tval, rdata;
  logic        ack, invalid, irq_pending;
  priv_level_t priv;

  row_t        rows[$];
  logic [31:0] lfsr;
  int          cycles = 0;
  int          cycle_limit = 1000;

  // Reference state
  csr_reg_t    m_mstatus, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  csr_reg_t    m_pma [PMA_REGIONS];
  priv_level_t m_priv;

  tb_clk #(.PERIOD(10), .RST_CYCLES(RST_CYCLES)) clk0 (.CLK, .nRST);

  priv_top #(.HARTID(HARTID), .PMA_REGIONS(PMA_REGIONS)) dut0 (
    .CLK, .nRST, .req, .op, .addr, .wdata, .epc, .cause, .tval,
    .inst_ret, .irq_timer, .irq_ext, .ack, .rdata, .invalid, .priv, .irq_pending
  );

  bind priv_ctrl priv_chk chk0 (.CLK(CLK), .nRST(nRST), .req(req), .ack(ack));

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output csr_reg_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic row_t csr_row(input csr_op_t o, input csr_addr_t a,
                                   input csr_reg_t wd);
    row_t r;
    r = '0;
    r.op = o;
    r.addr = a;
    r.wdata = wd;
    return r;
  endfunction

  function automatic row_t trap_row(input csr_reg_t e, input csr_reg_t c,
                                    input csr_reg_t tv);
    row_t r;
    r = '0;
    r.op = OP_TRAP;
    r.epc = e;
    r.cause = c;
    r.tval = tv;
    return r;
  endfunction

  task automatic model_csr(input row_t r, output csr_reg_t old_v, output logic bad);
    logic     is_wr, known;
    int       idx;
    csr_reg_t nv;
    is_wr = (r.op == OP_CSRRW) || (r.wdata != '0);  // Set/clear of zero only reads
    known = 1'b1;
    idx = int'(r.addr) - int'(PMA_BASE_ADDR);
    case (r.addr)
      MSTATUS_ADDR:  old_v = m_mstatus;
      MTVEC_ADDR:    old_v = m_mtvec;
      MSCRATCH_ADDR: old_v = m_mscratch;
      MEPC_ADDR:     old_v = m_mepc;
      MCAUSE_ADDR:   old_v = m_mcause;
      MTVAL_ADDR:    old_v = m_mtval;
      MHARTID_ADDR:  old_v = csr_reg_t'(HARTID);
      default: begin
        known = (idx >= 0) && (idx < PMA_REGIONS);
        old_v = known ? m_pma[idx] : '0;
      end
    endcase
    case (r.op)
      OP_CSRRS: nv = old_v | r.wdata;
      OP_CSRRC: nv = old_v & ~r.wdata;
      default:  nv = r.wdata;
    endcase
    bad = !known || (is_wr && (r.addr[9:8] > 2'(m_priv)));
    if (is_wr && !bad) begin
      case (r.addr)
        MSTATUS_ADDR: begin
          nv = nv & 32'h0022_1888;  // mie, mpie, mpp, mprv, tw
          if (nv[12:11] == 2'd1 || nv[12:11] == 2'd2)
            nv[12:11] = 2'd0;
          m_mstatus = nv;
        end
        MTVEC_ADDR: begin
          if (nv[1:0] > 2'd1)
            nv[1:0] = 2'd0;
          m_mtvec = nv;
        end
        MSCRATCH_ADDR: m_mscratch = nv;
        MEPC_ADDR:     m_mepc = nv;
        MCAUSE_ADDR:   m_mcause = nv;
        MTVAL_ADDR:    m_mtval = nv;
        MHARTID_ADDR:  ;  // Read-only
        default: begin
          if (m_pma[idx][31])
            bad = 1'b1;  // Locked entry
          else
            m_pma[idx] = nv;
        end
      endcase
    end
  endtask

  task automatic push_row(input row_t r_in);
    row_t     r;
    csr_reg_t old_v;
    logic     bad;
    r = r_in;
    case (r.op)
      OP_TRAP: begin
        old_v = {m_mtvec[31:2], 2'b00};
        if (m_mtvec[1:0] == 2'd1 && r.cause[31])
          old_v = old_v + (r.cause << 2);  // Vectored interrupt
        m_mepc = r.epc;
        m_mcause = r.cause;
        m_mtval = r.tval;
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
        m_mstatus[12:11] = m_priv;
        m_priv = M_MODE;
        bad = 1'b0;
      end
      OP_MRET: begin
        old_v = m_mepc;
        m_priv = priv_level_t'(m_mstatus[12:11]);
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        m_mstatus[12:11] = 2'd0;
        bad = 1'b0;
      end
      default: model_csr(r, old_v, bad);
    endcase
    r.exp_rdata = old_v;
    r.exp_invalid = bad;
    r.exp_priv = m_priv;
    rows.push_back(r);
  endtask

  task automatic build_table();
    csr_reg_t w1, w2, w3, w4;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    m_priv = M_MODE;
    foreach (m_pma[i])
      m_pma[i] = '0;
    // Reset values, then mscratch write/set/clear
    push_row(csr_row(OP_CSRRS, MSTATUS_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MTVEC_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MHARTID_ADDR, '0));
    rand_bits(32, w1);
    rand_bits(32, w2);
    rand_bits(32, w3);
    push_row(csr_row(OP_CSRRW, MSCRATCH_ADDR, w1));
    push_row(csr_row(OP_CSRRS, MSCRATCH_ADDR, w2));
    push_row(csr_row(OP_CSRRC, MSCRATCH_ADDR, w3));
    push_row(csr_row(OP_CSRRS, MSCRATCH_ADDR, '0));
    // Legal values
    push_row(csr_row(OP_CSRRW, MSTATUS_ADDR, 32'h0000_0808));  // mpp = S, mie
    push_row(csr_row(OP_CSRRS, MSTATUS_ADDR, '0));
    rand_bits(30, w1);
    push_row(csr_row(OP_CSRRW, MTVEC_ADDR, {w1[29:0], 2'b10}));  // Mode 2
    push_row(csr_row(OP_CSRRS, MTVEC_ADDR, '0));
    rand_bits(32, w1);
    push_row(csr_row(OP_CSRRW, 12'h123, w1));
    push_row(csr_row(OP_CSRRS, 12'h123, '0));
    push_row(csr_row(OP_CSRRS, MSCRATCH_ADDR, '0));
    // Exception trap in DIRECT mode
    rand_bits(32, w1);
    rand_bits(32, w2);
    push_row(trap_row(w1, 32'd2, w2));
    push_row(csr_row(OP_CSRRS, MEPC_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MCAUSE_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MTVAL_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MSTATUS_ADDR, '0));
    // Vectored mode, interrupt then exception
    rand_bits(30, w1);
    push_row(csr_row(OP_CSRRW, MTVEC_ADDR, {w1[29:0], 2'b01}));
    rand_bits(32, w2);
    push_row(trap_row(w2, 32'h8000_0007, '0));
    push_row(trap_row(w2, 32'd5, w2));
    // MRET to U, blocked write, read, trap back to M
    push_row(csr_row(OP_CSRRW, MSTATUS_ADDR, 32'h0000_0080));  // mpie, mpp = U
    rand_bits(30, w1);
    push_row(csr_row(OP_CSRRW, MEPC_ADDR, {w1[29:0], 2'b00}));
    push_row(csr_row(OP_MRET, '0, '0));
    rand_bits(32, w2);
    push_row(csr_row(OP_CSRRW, MSCRATCH_ADDR, w2));
    push_row(csr_row(OP_CSRRS, MSCRATCH_ADDR, '0));
    push_row(csr_row(OP_CSRRS, MSTATUS_ADDR, '0));
    push_row(trap_row(w1, 32'd8, '0));  // ecall from U
    push_row(csr_row(OP_CSRRS, MSTATUS_ADDR, '0));
    // PMA bank and lock
    rand_bits(31, w1);
    rand_bits(31, w2);
    rand_bits(31, w3);
    rand_bits(31, w4);
    push_row(csr_row(OP_CSRRW, PMA_BASE_ADDR, w1));
    push_row(csr_row(OP_CSRRW, PMA_BASE_ADDR + 12'd1, w2));
    push_row(csr_row(OP_CSRRS, PMA_BASE_ADDR, '0));
    push_row(csr_row(OP_CSRRS, PMA_BASE_ADDR + 12'd1, 32'h8000_0000));
    push_row(csr_row(OP_CSRRW, PMA_BASE_ADDR + 12'd1, w3));
    push_row(csr_row(OP_CSRRS, PMA_BASE_ADDR + 12'd1, '0));
    push_row(csr_row(OP_CSRRW, PMA_BASE_ADDR, w4));
    push_row(csr_row(OP_CSRRS, PMA_BASE_ADDR + 12'd3, '0));
    push_row(csr_row(OP_CSRRS, PMA_BASE_ADDR + 12'd4, '0));  // Just past the bank
  endtask

  // One four-phase transfer, outputs taken at the falling edge
  task automatic do_req(input row_t r, output csr_reg_t rd, output logic inv);
    @(posedge CLK);
    #DRIVE_DLY;
    op = r.op;
    addr = r.addr;
    wdata = r.wdata;
    epc = r.epc;
    cause = r.cause;
    tval = r.tval;
    req = 1'b1;
    @(negedge CLK);
    while (!ack) @(negedge CLK);
    rd = rdata;
    inv = invalid;
    @(posedge CLK);
    #DRIVE_DLY;
    req = 1'b0;
    @(negedge CLK);
    while (ack) @(negedge CLK);
  endtask

  task automatic wait_irq(input logic level, input int max_cyc);
    int n;
    n = 0;
    while (irq_pending !== level && n < max_cyc) begin
      @(negedge CLK);
      n++;
    end
    check_val("irq_pending", 32'(irq_pending), 32'(level));
  endtask

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin : main
    csr_reg_t rd, c1, c2;
    logic     inv;
    req = 1'b0;
    op = OP_CSRRW;
    addr = '0;
    wdata = '0;
    epc = '0;
    cause = '0;
    tval = '0;
    inst_ret = 1'b0;
    irq_timer = 1'b0;
    irq_ext = 1'b0;
    lfsr = 32'd4456;
    build_table();
    cycle_limit = (rows.size() + EXTRA_REQS) * 6 + RST_CYCLES + MARGIN;

    @(posedge nRST);
    @(negedge CLK);
    check_val("ack after reset", 32'(ack), 32'd0);
    check_val("priv after reset", 32'(priv), 32'(M_MODE));
    check_val("irq_pending after reset", 32'(irq_pending), 32'd0);

    foreach (rows[i]) begin
      do_req(rows[i], rd, inv);
      check_val($sformatf("row %0d rdata", i), rd, rows[i].exp_rdata);
      check_val($sformatf("row %0d invalid", i), 32'(inv), 32'(rows[i].exp_invalid));
      check_val($sformatf("row %0d priv", i), 32'(priv), 32'(rows[i].exp_priv));
    end

    // mcycle runs, then stops when inhibited
    do_req(csr_row(OP_CSRRS, MCYCLE_ADDR, '0), c1, inv);
    do_req(csr_row(OP_CSRRS, MCYCLE_ADDR, '0), c2, inv);
    check_val("mcycle increase", 32'(c2 > c1), 32'd1);
    do_req(csr_row(OP_CSRRW, MCOUNTINHIBIT_ADDR, 32'h0000_0001), rd, inv);
    check_val("mcountinhibit invalid", 32'(inv), 32'd0);
    do_req(csr_row(OP_CSRRS, MCYCLE_ADDR, '0), c1, inv);
    do_req(csr_row(OP_CSRRS, MCYCLE_ADDR, '0), c2, inv);
    check_val("inhibited mcycle", c2, c1);

    // Timer interrupt with mtie and mstatus.mie
    do_req(csr_row(OP_CSRRW, MIE_ADDR, 32'h0000_0080), rd, inv);
    do_req(csr_row(OP_CSRRW, MSTATUS_ADDR, 32'h0000_0008), rd, inv);
    check_val("irq_pending before timer", 32'(irq_pending), 32'd0);
    @(posedge CLK);
    #DRIVE_DLY;
    irq_timer = 1'b1;
    wait_irq(1'b1, 2);
    @(posedge CLK);
    #DRIVE_DLY;
    irq_timer = 1'b0;
    wait_irq(1'b0, 2);

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- sim/priv_chk.sv
/* Handshake checks for priv_ctrl, bound from the testbench.
   Covers the core side req/ack only, not the CSR traffic. */
`timescale 1ns/1ns

module priv_chk (
  input logic CLK,
  input logic nRST,
  input logic req,
  input logic ack
);

  // Cycle after the first edge out of reset
  ack_low_after_reset: assert property (@(posedge CLK) $rose(nRST) |=> !ack)
    else $error("ack high in the first cycle after reset release");

  // No ack without a request
  ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    (!ack && !req) |=> !ack)
    else $error("ack rose while req was low");

  ack_held: assert property (@(posedge CLK) disable iff (!nRST)
    (ack && req) |=> ack)  // Slow core keeps the unit in ACK
    else $error("ack dropped while req was still high");

endmodule

//--- sim/tb_clk.sv
/* Clock and reset for the privilege unit testbench.
   Reset is released a little after a rising edge. */
`timescale 1ns/1ns

module tb_clk #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 8
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    #2 nRST = 1'b1;  // Clear of the edge
  end

endmodule

//--- hw/priv_top.sv
/* Machine-mode privilege unit. Core side is a four-phase req/ack handshake;
   operands must stay stable while req is high. */
`timescale 1ns/1ns

module priv_top #(
  parameter int HARTID      = 0,
  parameter int PMA_REGIONS = 4
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  req,
  input  priv_pkg::csr_op_t     op,
  input  priv_pkg::csr_addr_t   addr,
  input  priv_pkg::csr_reg_t    wdata,
  input  priv_pkg::csr_reg_t    epc,
  input  priv_pkg::csr_reg_t    cause,
  input  priv_pkg::csr_reg_t    tval,
  input  logic                  inst_ret,
  input  logic                  irq_timer,
  input  logic                  irq_ext,
  output logic                  ack,
  output priv_pkg::csr_reg_t    rdata,
  output logic                  invalid,
  output priv_pkg::priv_level_t priv,
  output logic                  irq_pending
);
  import priv_pkg::*;

  csr_addr_t   csr_addr, ext_addr;
  logic        csr_write, csr_set, csr_clear, valid_write;
  csr_reg_t    new_csr_val, old_csr_val;
  priv_level_t curr_priv;
  logic        inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  mstatus_t    next_mstatus, curr_mstatus;
  csr_reg_t    next_mepc, next_mtval, curr_mepc;
  mcause_t     next_mcause;
  mip_t        next_mip, curr_mip;
  mie_t        curr_mie;
  mtvec_t      curr_mtvec;
  logic        invalid_csr;
  csr_reg_t    ext_value_in, ext_value_out;
  logic        ext_active, ext_ack, ext_invalid;

  priv_ctrl ctrl0 (
    .CLK, .nRST, .req, .op, .addr, .wdata, .epc, .cause, .tval,
    .irq_timer, .irq_ext, .ack, .rdata, .invalid, .priv, .irq_pending,
    .csr_addr, .csr_write, .csr_set, .csr_clear, .new_csr_val, .curr_priv,
    .valid_write, .inject_mstatus, .inject_mepc, .inject_mcause, .inject_mtval,
    .inject_mip, .next_mstatus, .next_mepc, .next_mcause, .next_mtval, .next_mip,
    .old_csr_val, .invalid_csr, .curr_mstatus, .curr_mtvec, .curr_mepc,
    .curr_mie, .curr_mip
  );

  priv_csr #(.HARTID(HARTID)) csr0 (
    .CLK, .nRST, .csr_addr, .csr_write, .csr_set, .csr_clear, .new_csr_val,
    .curr_priv, .valid_write, .inject_mstatus, .inject_mepc, .inject_mcause,
    .inject_mtval, .inject_mip, .next_mstatus, .next_mepc, .next_mcause,
    .next_mtval, .next_mip, .inst_ret, .old_csr_val, .invalid_csr,
    .curr_mstatus, .curr_mtvec, .curr_mepc, .curr_mie, .curr_mip,
    .ext_addr, .ext_value_in, .ext_active, .ext_ack, .ext_value_out, .ext_invalid
  );

  priv_pma_regs #(.PMA_REGIONS(PMA_REGIONS)) pma0 (
    .CLK, .nRST, .ext_addr, .ext_value_in, .ext_active,
    .ext_ack, .ext_value_out, .ext_invalid
  );

endmodule

//--- hw/priv_ctrl.sv
/* Request sequencer for the privilege unit. One request at a time over a
   four-phase req/ack handshake; all effects commit on the edge where ack
   rises. Trap and MRET state is built here and injected into the CSR file. */
`timescale 1ns/1ns

module priv_ctrl (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  req,
  input  priv_pkg::csr_op_t     op,
  input  priv_pkg::csr_addr_t   addr,
  input  priv_pkg::csr_reg_t    wdata,
  input  priv_pkg::csr_reg_t    epc,
  input  priv_pkg::csr_reg_t    cause,
  input  priv_pkg::csr_reg_t    tval,
  input  logic                  irq_timer,
  input  logic                  irq_ext,
  output logic                  ack,
  output priv_pkg::csr_reg_t    rdata,
  output logic                  invalid,
  output priv_pkg::priv_level_t priv,
  output logic                  irq_pending,
  output priv_pkg::csr_addr_t   csr_addr,
  output logic                  csr_write,
  output logic                  csr_set,
  output logic                  csr_clear,
  output priv_pkg::csr_reg_t    new_csr_val,
  output priv_pkg::priv_level_t curr_priv,
  output logic                  valid_write,
  output logic                  inject_mstatus,
  output logic                  inject_mepc,
  output logic                  inject_mcause,
  output logic                  inject_mtval,
  output logic                  inject_mip,
  output priv_pkg::mstatus_t    next_mstatus,
  output priv_pkg::csr_reg_t    next_mepc,
  output priv_pkg::mcause_t     next_mcause,
  output priv_pkg::csr_reg_t    next_mtval,
  output priv_pkg::mip_t        next_mip,
  input  priv_pkg::csr_reg_t    old_csr_val,
  input  logic                  invalid_csr,
  input  priv_pkg::mstatus_t    curr_mstatus,
  input  priv_pkg::mtvec_t      curr_mtvec,
  input  priv_pkg::csr_reg_t    curr_mepc,
  input  priv_pkg::mie_t        curr_mie,
  input  priv_pkg::mip_t        curr_mip
);
  import priv_pkg::*;

  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} state_t;

  state_t   state;
  logic     start, is_csr, trap_go, mret_go;
  csr_reg_t base_addr, handler, result;

  assign start   = (state == IDLE) & req;  // Single cycle per request
  assign is_csr  = op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC};
  assign trap_go = start & (op == OP_TRAP);
  assign mret_go = start & (op == OP_MRET);

  // Set/clear with zero data is a plain read and skips the privilege check
  assign valid_write = start & is_csr;
  assign csr_write   = valid_write & (op == OP_CSRRW);
  assign csr_set     = valid_write & (op == OP_CSRRS) & (|wdata);
  assign csr_clear   = valid_write & (op == OP_CSRRC) & (|wdata);
  assign csr_addr    = addr;
  assign new_csr_val = wdata;
  assign curr_priv   = priv;

  assign inject_mstatus = trap_go | mret_go;
  assign inject_mepc    = trap_go;
  assign inject_mcause  = trap_go;
  assign inject_mtval   = trap_go;
  assign next_mepc      = epc;
  assign next_mcause    = cause;
  assign next_mtval     = tval;

  always_comb begin
    next_mstatus = curr_mstatus;
    if (op == OP_MRET) begin
      next_mstatus.mie  = curr_mstatus.mpie;
      next_mstatus.mpie = 1'b1;
      next_mstatus.mpp  = U_MODE;
    end else begin
      next_mstatus.mpie = curr_mstatus.mie;
      next_mstatus.mie  = 1'b0;
      next_mstatus.mpp  = priv;
    end
  end

  // Handler address, cause[31] marks an interrupt
  assign base_addr = {curr_mtvec.base, 2'b00};
  assign handler   = (curr_mtvec.mode == VECTORED && cause[31]) ?
                     base_addr + {cause[29:0], 2'b00} : base_addr;

  always_comb begin
    case (op)
      OP_TRAP: result = handler;
      OP_MRET: result = curr_mepc;
      default: result = old_csr_val;
    endcase
  end

  // External interrupt lines follow the pins every cycle
  assign inject_mip = (curr_mip.mtip != irq_timer) | (curr_mip.meip != irq_ext);
  always_comb begin
    next_mip      = curr_mip;
    next_mip.mtip = irq_timer;
    next_mip.meip = irq_ext;
  end

  assign irq_pending = curr_mstatus.mie & (|(curr_mie & curr_mip));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      ack   <= 1'b0;
      priv  <= M_MODE;
    end else begin
      case (state)
        IDLE: if (req) begin
          state <= ACK;
          ack   <= 1'b1;
          if (trap_go)
            priv <= M_MODE;
          else if (mret_go)
            priv <= curr_mstatus.mpp;
        end
        ACK: if (!req) begin
          state <= WAIT_LOW;
          ack   <= 1'b0;
        end
        default: state <= IDLE;  // One guard cycle after ack falls
      endcase
    end
  end

  // Response payload, valid only while ack is high
  always_ff @(posedge CLK) begin
    if (start) begin
      rdata   <= result;
      invalid <= is_csr & invalid_csr;
    end
  end

endmodule

//--- hw/priv_pma_regs.sv
/* PMA configuration bank at PMA_BASE_ADDR + i. Bit 31 of each entry is a
   lock: once set, writes to that entry are dropped and flagged invalid.
   The attributes are stored only, nothing checks memory against them. */
`timescale 1ns/1ns

module priv_pma_regs #(
  parameter int PMA_REGIONS = 4
) (
  input  logic                CLK,
  input  logic                nRST,
  input  priv_pkg::csr_addr_t ext_addr,
  input  priv_pkg::csr_reg_t  ext_value_in,
  input  logic                ext_active,
  output logic                ext_ack,
  output priv_pkg::csr_reg_t  ext_value_out,
  output logic                ext_invalid
);
  import priv_pkg::*;

  localparam int IDX_W = (PMA_REGIONS > 1) ? $clog2(PMA_REGIONS) : 1;

  csr_reg_t   pma_cfg [PMA_REGIONS];
  csr_addr_t  offset;
  logic [IDX_W-1:0] idx;
  logic       locked;

  assign offset = ext_addr - PMA_BASE_ADDR;
  assign idx    = offset[IDX_W-1:0];
  assign ext_ack = (ext_addr >= PMA_BASE_ADDR) && (offset < csr_addr_t'(PMA_REGIONS));
  assign locked  = ext_ack & pma_cfg[idx][31];

  assign ext_value_out = ext_ack ? pma_cfg[idx] : '0;
  assign ext_invalid   = ext_active & locked;

  // Every entry starts zero and unlocked
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < PMA_REGIONS; i++)
        pma_cfg[i] <= '0;
    end else if (ext_active && ext_ack && !locked) begin
      pma_cfg[idx] <= ext_value_in;
    end
  end

endmodule

//--- hw/priv_csr.sv
/* Machine CSR file. Reads are combinational, writes commit on the next edge.
   Injected trap state wins over a software write on the same edge.
   mcycle/minstret are read-only here; mtip/meip only change by injection.
   Addresses not decoded here are forwarded to the PMA bank. */
`timescale 1ns/1ns

module priv_csr #(
  parameter int HARTID = 0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   csr_addr,
  input  logic                  csr_write,
  input  logic                  csr_set,
  input  logic                  csr_clear,
  input  priv_pkg::csr_reg_t    new_csr_val,
  input  priv_pkg::priv_level_t curr_priv,
  input  logic                  valid_write,
  input  logic                  inject_mstatus,
  input  logic                  inject_mepc,
  input  logic                  inject_mcause,
  input  logic                  inject_mtval,
  input  logic                  inject_mip,
  input  priv_pkg::mstatus_t    next_mstatus,
  input  priv_pkg::csr_reg_t    next_mepc,
  input  priv_pkg::mcause_t     next_mcause,
  input  priv_pkg::csr_reg_t    next_mtval,
  input  priv_pkg::mip_t        next_mip,
  input  logic                  inst_ret,
  output priv_pkg::csr_reg_t    old_csr_val,
  output logic                  invalid_csr,
  output priv_pkg::mstatus_t    curr_mstatus,
  output priv_pkg::mtvec_t      curr_mtvec,
  output priv_pkg::csr_reg_t    curr_mepc,
  output priv_pkg::mie_t        curr_mie,
  output priv_pkg::mip_t        curr_mip,
  output priv_pkg::csr_addr_t   ext_addr,
  output priv_pkg::csr_reg_t    ext_value_in,
  output logic                  ext_active,
  input  logic                  ext_ack,
  input  priv_pkg::csr_reg_t    ext_value_out,
  input  logic                  ext_invalid
);
  import priv_pkg::*;

  mstatus_t       mstatus, mstatus_next;
  mtvec_t         mtvec, mtvec_next;
  mie_t           mie, mie_next;
  mip_t           mip, mip_next;
  csr_reg_t       mscratch, mscratch_next;
  csr_reg_t       mepc, mepc_next;
  mcause_t        mcause, mcause_next;
  csr_reg_t       mtval, mtval_next;
  mcounteren_t    mcounteren, mcounteren_next;
  mcountinhibit_t mcountinhibit, mcountinhibit_next;
  long_csr_t      cycles_full, instret_full;

  csr_reg_t    nxt_csr_val;
  priv_level_t mpp_w;
  logic        wr_any;
  logic        priv_fail;  // Write above current level
  logic        addr_known;
  logic        commit;

  assign wr_any    = csr_write | csr_set | csr_clear;
  assign priv_fail = wr_any & (csr_addr[9:8] > curr_priv);
  assign commit    = valid_write & wr_any & ~priv_fail;

  assign nxt_csr_val = csr_set   ? (old_csr_val | new_csr_val) :
                       csr_clear ? (old_csr_val & ~new_csr_val) :
                       new_csr_val;
  assign mpp_w = priv_level_t'(nxt_csr_val[12:11]);

  // Broadcast to the PMA bank
  assign ext_addr     = csr_addr;
  assign ext_value_in = nxt_csr_val;
  assign ext_active   = commit;

  assign invalid_csr = priv_fail | ~addr_known | ext_invalid;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= '0;  // mpp = U, mie = 0
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1;
      mcountinhibit <= '0;
      cycles_full   <= '0;
      instret_full  <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
      if (mcounteren.cy & ~mcountinhibit.cy)
        cycles_full <= cycles_full + 64'd1;
      if (mcounteren.ir & ~mcountinhibit.ir)
        instret_full <= instret_full + 64'(inst_ret);
    end
  end

  // Software writes with legal-value rules, then injection
  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (commit) begin
      case (csr_addr)
        MSTATUS_ADDR: begin
          mstatus_next.mie  = nxt_csr_val[3];
          mstatus_next.mpie = nxt_csr_val[7];
          mstatus_next.mprv = nxt_csr_val[17];
          mstatus_next.tw   = nxt_csr_val[21];
          // S and reserved levels do not exist, fall back to U
          if (mpp_w == S_MODE || mpp_w == RESERVED_MODE)
            mstatus_next.mpp = U_MODE;
          else
            mstatus_next.mpp = mpp_w;
        end
        MTVEC_ADDR: begin
          mtvec_next.base = nxt_csr_val[31:2];
          if (nxt_csr_val[1:0] > 2'b01)
            mtvec_next.mode = DIRECT;
          else
            mtvec_next.mode = vector_modes_t'(nxt_csr_val[1:0]);
        end
        MIE_ADDR: begin
          mie_next.msie = nxt_csr_val[3];
          mie_next.mtie = nxt_csr_val[7];
          mie_next.meie = nxt_csr_val[11];
        end
        MIP_ADDR:           mip_next.msip = nxt_csr_val[3];  // Software interrupt only
        MSCRATCH_ADDR:      mscratch_next = nxt_csr_val;
        MEPC_ADDR:          mepc_next = nxt_csr_val;
        MCAUSE_ADDR:        mcause_next = nxt_csr_val;
        MTVAL_ADDR:         mtval_next = nxt_csr_val;
        MCOUNTEREN_ADDR:    mcounteren_next = nxt_csr_val;
        MCOUNTINHIBIT_ADDR: mcountinhibit_next = nxt_csr_val;
        default: ;
      endcase
    end

    if (inject_mstatus)
      mstatus_next = next_mstatus;
    if (inject_mepc)
      mepc_next = next_mepc;
    if (inject_mcause)
      mcause_next = next_mcause;
    if (inject_mtval)
      mtval_next = next_mtval;
    if (inject_mip) begin
      mip_next.mtip = next_mip.mtip;
      mip_next.meip = next_mip.meip;
    end
  end

  // Read mux, PMA bank answers for anything not decoded here
  always_comb begin
    old_csr_val = '0;
    addr_known  = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR:     old_csr_val = '0;
      MHARTID_ADDR:       old_csr_val = csr_reg_t'(HARTID);
      MISA_ADDR:          old_csr_val = MISA_VALUE;
      MSTATUS_ADDR:       old_csr_val = mstatus;
      MTVEC_ADDR:         old_csr_val = mtvec;
      MIE_ADDR:           old_csr_val = mie;
      MIP_ADDR:           old_csr_val = mip;
      MSCRATCH_ADDR:      old_csr_val = mscratch;
      MEPC_ADDR:          old_csr_val = mepc;
      MCAUSE_ADDR:        old_csr_val = mcause;
      MTVAL_ADDR:         old_csr_val = mtval;
      MCOUNTEREN_ADDR:    old_csr_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_csr_val = mcountinhibit;
      MCYCLE_ADDR:        old_csr_val = cycles_full[31:0];
      MCYCLEH_ADDR:       old_csr_val = cycles_full[63:32];
      MINSTRET_ADDR:      old_csr_val = instret_full[31:0];
      MINSTRETH_ADDR:     old_csr_val = instret_full[63:32];
      default: begin
        old_csr_val = ext_value_out;
        addr_known  = ext_ack;
      end
    endcase
  end

  assign curr_mstatus = mstatus;
  assign curr_mtvec   = mtvec;
  assign curr_mepc    = mepc;
  assign curr_mie     = mie;
  assign curr_mip     = mip;

endmodule

//--- hw/priv_pkg.sv
/* Types, CSR map and request opcodes shared by the privilege unit.
   Only M and U levels exist in hardware. S_MODE and RESERVED_MODE are
   kept so that the MPP legal-value check can name them. */
package priv_pkg;

  typedef logic [31:0] csr_reg_t;
  typedef logic [63:0] long_csr_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_modes_t;

  typedef enum logic [2:0] {
    OP_CSRRW = 3'd0,
    OP_CSRRS = 3'd1,
    OP_CSRRC = 3'd2,
    OP_TRAP  = 3'd3,
    OP_MRET  = 3'd4
  } csr_op_t;

  typedef struct packed {
    logic [9:0]  reserved_4;
    logic        tw;          // 21
    logic [2:0]  reserved_3;
    logic        mprv;        // 17
    logic [3:0]  reserved_2;
    priv_level_t mpp;         // 12:11
    logic [2:0]  reserved_1;
    logic        mpie;        // 7
    logic [2:0]  reserved_0;
    logic        mie;         // 3
    logic [2:0]  reserved_low;
  } mstatus_t;

  typedef struct packed {
    logic [29:0]   base;
    vector_modes_t mode;
  } mtvec_t;

  typedef struct packed {
    logic [19:0] reserved_2;
    logic        meie;
    logic [2:0]  reserved_1;
    logic        mtie;
    logic [2:0]  reserved_0;
    logic        msie;
    logic [2:0]  reserved_low;
  } mie_t;

  typedef struct packed {
    logic [19:0] reserved_2;
    logic        meip;
    logic [2:0]  reserved_1;
    logic        mtip;
    logic [2:0]  reserved_0;
    logic        msip;
    logic [2:0]  reserved_low;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] cause;
  } mcause_t;

  typedef struct packed {
    logic [28:0] reserved;
    logic        ir;
    logic        tm;
    logic        cy;
  } mcounteren_t;

  typedef mcounteren_t mcountinhibit_t;

  // RV32, extensions I and U
  localparam csr_reg_t MISA_VALUE = 32'h4010_0100;

  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;

  localparam csr_addr_t PMA_BASE_ADDR      = 12'h7C0; // Custom bank, M-level

endpackage
